/* logic/mext_isa_pkg.sv */
// m-extension instruction encodings
`default_nettype none

package mext_isa_pkg;

    // register index width, x0..x31
    localparam int unsigned REG_ADDR_W = 5;

    // major opcode of the r-type integer group
    localparam logic [6:0] OPCODE_OP = 7'b0110011;

    // funct7 shared by mul/div/rem
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // funct3 of the multiply forms
    localparam logic [2:0] FUNCT3_MUL    = 3'b000; // low half
    localparam logic [2:0] FUNCT3_MULH   = 3'b001; // high, signed x signed
    localparam logic [2:0] FUNCT3_MULHSU = 3'b010; // high, signed x unsigned
    localparam logic [2:0] FUNCT3_MULHU  = 3'b011; // high, unsigned x unsigned
    // 100..111 are div/rem, not handled here

    // one-hot multiply op, carried from decode into the multiplier
    typedef enum logic [3:0] {
        MUL_OP_MUL    = 4'b0001,
        MUL_OP_MULH   = 4'b0010,
        MUL_OP_MULHSU = 4'b0100,
        MUL_OP_MULHU  = 4'b1000
    } mul_op_t;

endpackage

`default_nettype wire

/* logic/mext_cfg_pkg.sv */
// multiply unit configuration
`default_nettype none

package mext_cfg_pkg;

    // datapath width, 64 also works (halves of XLEN/2)
    localparam int unsigned XLEN_DEFAULT = 32;

    // block products per multiply, one per calc cycle
    localparam int unsigned MUL_STEPS = 4;

    // block multiplier sequencing
    typedef enum logic [1:0] {
        ST_IDLE   = 2'b00, // waiting for start and a free result slot
        ST_CALC   = 2'b01, // one block product per cycle
        ST_OUTPUT = 2'b10  // sum, sign fix, half select
    } mul_state_t;

endpackage

`default_nettype wire

/* logic/mul_decode.sv */
// multiply instruction decode and issue
`default_nettype none
`timescale 1ns/1ps

module mul_decode import mext_isa_pkg::*; #(
    parameter int unsigned XLEN = 32
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  instr_valid_i,
    input  wire logic [31:0]           instr_i,
    input  wire logic [XLEN-1:0]       rs1_data_i,
    input  wire logic [XLEN-1:0]       rs2_data_i,
    input  wire logic                  mul_valid_i,    // multiplier done, frees the issue slot
    output logic                       instr_ready_o,
    output logic                       illegal_o,
    output logic                       start_o,
    output mul_op_t                    op_o,
    output logic [XLEN-1:0]            multiplicand_o,
    output logic [XLEN-1:0]            multiplier_o,
    output logic [REG_ADDR_W-1:0]      rd_o
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       is_mul;        // one of the four multiply forms
    mul_op_t    op_dec;
    logic       accept;        // handshake on the instruction port
    logic       issue_full_q;
    logic       illegal_q;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // funct3 -> one-hot op
    always_comb begin
        op_dec = MUL_OP_MUL;
        is_mul = 1'b0;
        if (opcode == OPCODE_OP && funct7 == FUNCT7_MULDIV) begin
            is_mul = 1'b1;
            case (funct3)
                FUNCT3_MUL:    op_dec = MUL_OP_MUL;
                FUNCT3_MULH:   op_dec = MUL_OP_MULH;
                FUNCT3_MULHSU: op_dec = MUL_OP_MULHSU;
                FUNCT3_MULHU:  op_dec = MUL_OP_MULHU;
                default:       is_mul = 1'b0; // div/rem rejected
            endcase
        end
    end

    // also held off during an illegal pulse, so pulses never merge
    assign instr_ready_o = !issue_full_q && !illegal_q;
    assign accept        = instr_valid_i && instr_ready_o;

    // issue slot and reject pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_full_q <= 1'b0;
            illegal_q    <= 1'b0;
        end else begin
            illegal_q <= accept && !is_mul; // one cycle after the reject
            if (accept && is_mul)
                issue_full_q <= 1'b1;
            else if (mul_valid_i)
                issue_full_q <= 1'b0;       // result handed to the result stage
        end
    end

    // issue payload
    always_ff @(posedge clk) begin
        if (accept && is_mul) begin
            op_o           <= op_dec;
            multiplicand_o <= rs1_data_i;
            multiplier_o   <= rs2_data_i;
            rd_o           <= instr_i[7 +: REG_ADDR_W];
        end
    end

    assign start_o   = issue_full_q; // held until mul_valid_i
    assign illegal_o = illegal_q;

endmodule

`default_nettype wire

/* logic/mul_block_exec.sv */
// block multiplier, four half-width products
`default_nettype none
`timescale 1ns/1ps

module mul_block_exec import mext_isa_pkg::*, mext_cfg_pkg::*; #(
    parameter int unsigned XLEN = 32
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            start_i,
    input  wire mul_op_t         op_i,
    input  wire logic [XLEN-1:0] multiplicand_i,
    input  wire logic [XLEN-1:0] multiplier_i,
    input  wire logic            slot_free_i,    // result stage can take one more
    output logic [XLEN-1:0]      result_o,
    output logic                 busy_o,
    output logic                 valid_o         // one-cycle done pulse
);

    localparam int unsigned HALF   = XLEN / 2;
    localparam int unsigned STEP_W = $clog2(MUL_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(MUL_STEPS - 1);

    mul_state_t        state_q;
    mul_state_t        state_d;
    logic [STEP_W-1:0] step_q;       // selects the block pair
    mul_op_t           op_q;
    logic              sign_q;       // product sign for signed forms
    logic [HALF-1:0]   a_lo_q;
    logic [HALF-1:0]   a_hi_q;
    logic [HALF-1:0]   b_lo_q;
    logic [HALF-1:0]   b_hi_q;
    logic [XLEN-1:0]   blk_q [MUL_STEPS];

    logic              cand_signed;
    logic              plier_signed;
    logic              cand_neg;
    logic              plier_neg;
    logic [XLEN-1:0]   cand_abs;
    logic [XLEN-1:0]   plier_abs;
    logic [HALF-1:0]   mul_a;
    logic [HALF-1:0]   mul_b;
    logic [XLEN-1:0]   blk_prod;
    logic [2*XLEN-1:0] prod_mag;
    logic [2*XLEN-1:0] prod_full;
    logic              capture;

    // operand signedness per op
    assign cand_signed  = (op_i != MUL_OP_MULHU);                     // MUL, MULH, MULHSU
    assign plier_signed = (op_i == MUL_OP_MUL) || (op_i == MUL_OP_MULH);
    assign cand_neg     = cand_signed && multiplicand_i[XLEN-1];
    assign plier_neg    = plier_signed && multiplier_i[XLEN-1];

    // magnitudes, min value maps onto itself as unsigned 2^(XLEN-1)
    assign cand_abs  = cand_neg ? -multiplicand_i : multiplicand_i;
    assign plier_abs = plier_neg ? -multiplier_i : multiplier_i;

    // no restart while the done pulse is still out, start is still high then
    assign capture = (state_q == ST_IDLE) && start_i && slot_free_i && !valid_o;

    // shared half-width multiplier
    // step 0: lo*lo, 1: lo*hi, 2: hi*lo, 3: hi*hi
    assign mul_a    = step_q[1] ? a_hi_q : a_lo_q;
    assign mul_b    = step_q[0] ? b_hi_q : b_lo_q;
    assign blk_prod = {{HALF{1'b0}}, mul_a} * {{HALF{1'b0}}, mul_b};

    // shift and sum the blocks
    assign prod_mag = {{XLEN{1'b0}}, blk_q[0]}
                    + {{HALF{1'b0}}, blk_q[1], {HALF{1'b0}}}
                    + {{HALF{1'b0}}, blk_q[2], {HALF{1'b0}}}
                    + {blk_q[3], {XLEN{1'b0}}};

    // MULHU is never negated
    assign prod_full = (sign_q && op_q != MUL_OP_MULHU) ? -prod_mag : prod_mag;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (capture)
                    state_d = ST_CALC;
            end
            ST_CALC: begin
                if (step_q == LAST_STEP)
                    state_d = ST_OUTPUT; // all four blocks stored
            end
            ST_OUTPUT: state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            step_q  <= '0;
            busy_o  <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            valid_o <= (state_q == ST_OUTPUT); // pulse on leaving output
            if (capture) begin
                step_q <= '0;
                busy_o <= 1'b1;
            end else if (state_q == ST_CALC) begin
                step_q <= step_q + 1'b1;
            end else if (state_q == ST_OUTPUT) begin
                busy_o <= 1'b0;
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (capture) begin
            op_q   <= op_i;
            sign_q <= cand_neg ^ plier_neg;
            a_lo_q <= cand_abs[HALF-1:0];
            a_hi_q <= cand_abs[XLEN-1:HALF];
            b_lo_q <= plier_abs[HALF-1:0];
            b_hi_q <= plier_abs[XLEN-1:HALF];
        end
        if (state_q == ST_CALC)
            blk_q[step_q] <= blk_prod;
        if (state_q == ST_OUTPUT) begin
            // low half for MUL, high half for the rest
            if (op_q == MUL_OP_MUL)
                result_o <= prod_full[XLEN-1:0];
            else
                result_o <= prod_full[2*XLEN-1:XLEN];
        end
    end

endmodule

`default_nettype wire

/* logic/mul_result.sv */
// one-entry result register
`default_nettype none
`timescale 1ns/1ps

module mul_result import mext_isa_pkg::*; #(
    parameter int unsigned XLEN = 32
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  mul_valid_i,   // done pulse from the multiplier
    input  wire logic [XLEN-1:0]       mul_data_i,
    input  wire logic [REG_ADDR_W-1:0] rd_i,          // from the issue register
    input  wire logic                  result_ready_i,
    output logic                       slot_free_o,
    output logic                       result_valid_o,
    output logic [XLEN-1:0]            result_data_o,
    output logic [REG_ADDR_W-1:0]      result_rd_o
);

    logic full_q;
    logic load;     // writes to x0 are dropped here

    assign load = mul_valid_i && (rd_i != '0);

    // empty, or emptied by the consumer this cycle
    assign slot_free_o = !full_q || result_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else begin
            if (load)
                full_q <= 1'b1;
            else if (result_ready_i)
                full_q <= 1'b0; // taken by the consumer
        end
    end

    // payload stays put until taken
    always_ff @(posedge clk) begin
        if (load) begin
            result_data_o <= mul_data_i;
            result_rd_o   <= rd_i;
        end
    end

    assign result_valid_o = full_q;

endmodule

`default_nettype wire

/* logic/mul_unit_top.sv */
// risc-v multiply unit top
`default_nettype none
`timescale 1ns/1ps

module mul_unit_top import mext_isa_pkg::*, mext_cfg_pkg::*; #(
    parameter int unsigned XLEN = XLEN_DEFAULT
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  instr_valid_i,
    input  wire logic [31:0]           instr_i,
    input  wire logic [XLEN-1:0]       rs1_data_i,
    input  wire logic [XLEN-1:0]       rs2_data_i,
    output logic                       instr_ready_o,
    output logic                       illegal_o,
    input  wire logic                  result_ready_i,
    output logic                       result_valid_o,
    output logic [XLEN-1:0]            result_data_o,
    output logic [REG_ADDR_W-1:0]      result_rd_o
);

    // decode -> execute
    logic                  start;
    mul_op_t               op;
    logic [XLEN-1:0]       multiplicand;
    logic [XLEN-1:0]       multiplier;
    logic [REG_ADDR_W-1:0] rd;        // rides with the operands to the result stage

    // execute -> decode / result
    logic [XLEN-1:0]       mul_result;
    logic                  busy;
    logic                  valid;
    logic                  slot_free; // result -> execute

    mul_decode #(.XLEN(XLEN)) u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .mul_valid_i    (valid),
        .instr_ready_o  (instr_ready_o),
        .illegal_o      (illegal_o),
        .start_o        (start),
        .op_o           (op),
        .multiplicand_o (multiplicand),
        .multiplier_o   (multiplier),
        .rd_o           (rd)
    );

    mul_block_exec #(.XLEN(XLEN)) u_exec (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start),
        .op_i           (op),
        .multiplicand_i (multiplicand),
        .multiplier_i   (multiplier),
        .slot_free_i    (slot_free),
        .result_o       (mul_result),
        .busy_o         (busy),
        .valid_o        (valid)
    );

    mul_result #(.XLEN(XLEN)) u_result (
        .clk            (clk),
        .rst_n          (rst_n),
        .mul_valid_i    (valid),
        .mul_data_i     (mul_result),
        .rd_i           (rd),
        .result_ready_i (result_ready_i),
        .slot_free_o    (slot_free),
        .result_valid_o (result_valid_o),
        .result_data_o  (result_data_o),
        .result_rd_o    (result_rd_o)
    );

endmodule

`default_nettype wire

/* sim/mul_unit_checker.sv */
// multiply unit handshake assertions
`default_nettype none
`timescale 1ns/1ps

module mul_unit_checker import mext_isa_pkg::*; #(
    parameter int unsigned XLEN = 32
) (
    input wire logic                  clk,
    input wire logic                  rst_n,
    input wire logic                  instr_ready_i,
    input wire logic                  illegal_i,
    input wire logic                  busy_i,         // multiplier running on the held instruction
    input wire logic                  result_valid_i,
    input wire logic                  result_ready_i,
    input wire logic [XLEN-1:0]       result_data_i,
    input wire logic [REG_ADDR_W-1:0] result_rd_i
);

    // waiting result stays up, payload frozen
    result_held: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_data_i)
            && $stable(result_rd_i))
        else $error("result changed or vanished before it was taken");

    illegal_single: assert property (@(posedge clk) disable iff (!rst_n)
        illegal_i |=> !illegal_i)  // one cycle per rejected instruction
        else $error("illegal pulse lasted more than one cycle");

    // a running multiply still occupies the issue register
    ready_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        busy_i |-> !instr_ready_i)
        else $error("instruction port ready while the issue register is full");

endmodule

bind mul_unit_top mul_unit_checker #(.XLEN(XLEN)) u_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_ready_i  (instr_ready_o),
    .illegal_i      (illegal_o),
    .busy_i         (busy),
    .result_valid_i (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_data_i  (result_data_o),
    .result_rd_i    (result_rd_o)
);

`default_nettype wire

/* sim/mul_unit_tb.sv */
// multiply unit testbench
`default_nettype none
`timescale 1ns/1ps

module mul_unit_tb import mext_isa_pkg::*, mext_cfg_pkg::*; #(
    parameter int unsigned XLEN = XLEN_DEFAULT
) ();

    localparam logic [31:0] SEED    = 32'd7387;
    localparam int N_CORNER         = 100;    // 4 ops x 5 x 5 corner values
    localparam int N_RANDOM         = 40;
    localparam int N_GAPS           = 40;
    localparam int N_RD_ZERO        = 16;
    localparam int N_ILLEGAL        = 8;
    localparam int N_B2B            = 12;
    localparam int N_TOTAL          = N_CORNER + N_RANDOM + N_GAPS + N_RD_ZERO + N_ILLEGAL + N_B2B;
    localparam int TIMEOUT_CYCLES   = N_TOTAL * 20 + 400;
    localparam int LATENCY          = 7;      // accept edge to result_valid_o rise
    localparam logic [XLEN-1:0] MIN_VAL = {1'b1, {(XLEN-1){1'b0}}};

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid_i;
    logic [31:0]           instr_i;
    logic [XLEN-1:0]       rs1_data_i;
    logic [XLEN-1:0]       rs2_data_i;
    logic                  instr_ready_o;
    logic                  illegal_o;
    logic                  result_ready_i;
    logic                  result_valid_o;
    logic [XLEN-1:0]       result_data_o;
    logic [REG_ADDR_W-1:0] result_rd_o;

    logic [31:0] stim_state = SEED;   // operands, rd, ops
    logic [31:0] gap_state  = SEED;   // ready gaps, own stream
    bit          gap_mode   = 1'b0;
    string       test_name  = "reset";
    int cycle_cnt    = 0;             // rising edges so far
    int error_count  = 0;
    int check_count  = 0;
    int result_count = 0;
    int issued_count = 0;             // results owed by the DUT
    int illegal_seen = 0;
    int illegal_exp  = 0;

    // expected results in issue order
    logic [REG_ADDR_W-1:0] exp_rd_q [$];
    logic [XLEN-1:0]       exp_data_q [$];
    int                    exp_edge_q [$];  // accept edge
    bit                    exp_lat_q [$];   // latency checked for this one

    mul_unit_top #(.XLEN(XLEN)) uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .instr_ready_o  (instr_ready_o),
        .illegal_o      (illegal_o),
        .result_ready_i (result_ready_i),
        .result_valid_o (result_valid_o),
        .result_data_o  (result_data_o),
        .result_rd_o    (result_rd_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // upper lcg bits only, low ones cycle fast
    function automatic logic [XLEN-1:0] rand_word();
        logic [XLEN-1:0] w;
        w = '0;
        for (int i = 0; i < XLEN; i += 16) begin
            stim_state = lcg_step(stim_state);
            w[i +: 16] = stim_state[31:16];
        end
        return w;
    endfunction

    function automatic logic [REG_ADDR_W-1:0] rand_rd();
        stim_state = lcg_step(stim_state);
        return REG_ADDR_W'(stim_state[31:16] % 31) + 1'b1; // x1..x31
    endfunction

    function automatic mul_op_t op_of_funct3(input logic [2:0] f3);
        case (f3)
            FUNCT3_MULH:   return MUL_OP_MULH;
            FUNCT3_MULHSU: return MUL_OP_MULHSU;
            FUNCT3_MULHU:  return MUL_OP_MULHU;
            default:       return MUL_OP_MUL;
        endcase
    endfunction

    // isa rule: rs1 signed unless MULHU, rs2 signed only for MUL and MULH
    function automatic logic [XLEN-1:0] expected_product(input mul_op_t op,
                                                         input logic [XLEN-1:0] a,
                                                         input logic [XLEN-1:0] b);
        logic              a_sx;
        logic              b_sx;
        logic [2*XLEN-1:0] ax;
        logic [2*XLEN-1:0] bx;
        logic [2*XLEN-1:0] p;
        a_sx = (op != MUL_OP_MULHU) && a[XLEN-1];
        b_sx = (op == MUL_OP_MUL || op == MUL_OP_MULH) && b[XLEN-1];
        ax   = {{XLEN{a_sx}}, a};
        bx   = {{XLEN{b_sx}}, b};
        p    = ax * bx;   // full product mod 2^(2*XLEN)
        return (op == MUL_OP_MUL) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
    endfunction

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Error: %s data expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_rd(input string name, input logic [REG_ADDR_W-1:0] exp,
                            input logic [REG_ADDR_W-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Error: %s rd expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_int(input string name, input int exp, input int act);
        check_count++;
        if (act != exp) begin
            error_count++;
            $display("Error: %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // one instruction, called just after a falling edge
    task automatic issue_instr(input logic [6:0] opcode, input logic [6:0] funct7,
                               input logic [2:0] funct3, input logic [REG_ADDR_W-1:0] rd,
                               input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                               input bit chk_lat, output int waited);
        bit legal;
        legal = (opcode == OPCODE_OP) && (funct7 == FUNCT7_MULDIV) && !funct3[2];
        instr_valid_i = 1'b1;
        instr_i       = {funct7, 5'd2, 5'd1, funct3, rd, opcode};  // rs2 x2, rs1 x1
        rs1_data_i    = a;
        rs2_data_i    = b;
        waited        = 0;
        while (!instr_ready_o) begin   // valid held until ready
            @(negedge clk);
            waited++;
        end
        if (legal && rd != '0) begin   // x0 writes never come back
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(expected_product(op_of_funct3(funct3), a, b));
            exp_edge_q.push_back(cycle_cnt + 1); // taken on the coming rising edge
            exp_lat_q.push_back(chk_lat);
            issued_count++;
        end
        if (!legal)
            illegal_exp++;
        @(negedge clk);
        instr_valid_i = 1'b0;
        check_flag({test_name, " illegal_o"}, !legal, illegal_o);
    endtask

    task automatic wait_drain();
        while (exp_rd_q.size() != 0)
            @(negedge clk);
        repeat (12) @(negedge clk); // room for a stray result
    endtask

    // drives result_ready_i and checks every transfer
    initial begin : compare_results
        logic [REG_ADDR_W-1:0] rd_e;
        logic [XLEN-1:0]       data_e;
        int                    edge_e;
        bit                    lat_e;
        bit                    waiting;
        int                    rise_edge;
        result_ready_i = 1'b1;
        waiting        = 1'b0;
        rise_edge      = 0;
        forever begin
            @(negedge clk);
            if (gap_mode) begin
                gap_state      = lcg_step(gap_state);
                result_ready_i = gap_state[19]; // low about half the cycles
            end else begin
                result_ready_i = 1'b1;
            end
            if (illegal_o)
                illegal_seen++;
            if (result_valid_o && !waiting)
                rise_edge = cycle_cnt;          // fresh result
            waiting = result_valid_o && !result_ready_i;
            if (result_valid_o && result_ready_i) begin // taken on the next rising edge
                result_count++;
                if (exp_rd_q.size() == 0) begin
                    error_count++;
                    $display("Error: %s result rd %0d data %h arrived with nothing outstanding",
                             test_name, result_rd_o, result_data_o);
                end else begin
                    rd_e   = exp_rd_q.pop_front();
                    data_e = exp_data_q.pop_front();
                    edge_e = exp_edge_q.pop_front();
                    lat_e  = exp_lat_q.pop_front();
                    check_rd(test_name, rd_e, result_rd_o);
                    check_data(test_name, data_e, result_data_o);
                    if (lat_e)
                        check_int({test_name, " latency"}, LATENCY, rise_edge - edge_e);
                end
            end
        end
    end

    initial begin : run_tests
        logic [XLEN-1:0]       corner [5];
        logic [REG_ADDR_W-1:0] rd;
        int                    waited;
        corner[0] = '0;
        corner[1] = XLEN'(1);
        corner[2] = '1;          // -1
        corner[3] = MIN_VAL;
        corner[4] = ~MIN_VAL;    // max positive
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_flag("reset instr_ready_o", 1'b1, instr_ready_o);
        check_flag("reset illegal_o", 1'b0, illegal_o);
        check_flag("reset result_valid_o", 1'b0, result_valid_o);

        test_name = "corner";
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issue_instr(OPCODE_OP, FUNCT7_MULDIV, 3'(op), rand_rd(), corner[i],
                                corner[j], 1'b1, waited);
                end
            end
        end
        wait_drain();

        test_name = "random";
        for (int n = 0; n < N_RANDOM; n++) begin
            issue_instr(OPCODE_OP, FUNCT7_MULDIV, 3'(rand_word() % 4), rand_rd(),
                        rand_word(), rand_word(), 1'b1, waited);
        end
        wait_drain();

        test_name = "ready_gaps";
        gap_mode  = 1'b1;
        for (int n = 0; n < N_GAPS; n++) begin
            issue_instr(OPCODE_OP, FUNCT7_MULDIV, 3'(rand_word() % 4), rand_rd(),
                        rand_word(), rand_word(), 1'b0, waited);
        end
        wait_drain();
        gap_mode = 1'b0;

        test_name = "rd_zero";
        for (int n = 0; n < N_RD_ZERO; n++) begin
            rd = n[0] ? rand_rd() : '0;  // every other one targets x0
            issue_instr(OPCODE_OP, FUNCT7_MULDIV, 3'(rand_word() % 4), rd,
                        rand_word(), rand_word(), 1'b1, waited);
        end
        wait_drain();

        test_name = "illegal";
        for (int f = 4; f < 8; f++) begin  // div, divu, rem, remu
            issue_instr(OPCODE_OP, FUNCT7_MULDIV, 3'(f), rand_rd(), rand_word(),
                        rand_word(), 1'b0, waited);
        end
        issue_instr(OPCODE_OP, 7'b0000000, FUNCT3_MUL, rand_rd(), 1, 2, 1'b0, waited); // add
        issue_instr(OPCODE_OP, 7'b0100000, FUNCT3_MUL, rand_rd(), 1, 2, 1'b0, waited); // sub
        issue_instr(7'b0111011, FUNCT7_MULDIV, FUNCT3_MUL, rand_rd(), 3, 4, 1'b0, waited);
        issue_instr(7'b0010011, FUNCT7_MULDIV, FUNCT3_MULH, rand_rd(), 3, 4, 1'b0, waited);
        wait_drain();

        test_name = "back_to_back";
        for (int n = 0; n < N_B2B; n++) begin
            issue_instr(OPCODE_OP, FUNCT7_MULDIV, 3'(rand_word() % 4), rand_rd(),
                        rand_word(), rand_word(), 1'b1, waited);
            check_flag("back_to_back instr_ready_o held low", 1'b0, instr_ready_o);
            if (n > 0)
                check_flag("back_to_back issue stalled", 1'b1, waited > 0);
        end
        wait_drain();

        check_int("summary result count", issued_count, result_count);
        check_int("summary illegal pulses", illegal_exp, illegal_seen);
        $display("checks %0d, errors %0d, results %0d, illegal pulses %0d",
                 check_count, error_count, result_count, illegal_seen);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // bound on the whole run
    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the unit stopped making progress", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
logic/mext_isa_pkg.sv
logic/mext_cfg_pkg.sv
logic/mul_decode.sv
logic/mul_block_exec.sv
logic/mul_result.sv
logic/mul_unit_top.sv
sim/mul_unit_checker.sv
sim/mul_unit_tb.sv

/* Makefile */
# Verilator build and run of the multiply unit testbench

VERILATOR ?= verilator
TOP       ?= mul_unit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output goes to the terminal, the pass line decides the status
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
